// ==== axi_bridge.f ====
source/axi_bridge_pkg.sv
source/axi_ar_channel.sv
source/axi_r_channel.sv
source/axi_aw_channel.sv
source/w_beat_fifo.sv
source/write_pending_counter.sv
source/axi_bridge.sv
tests/axi_slave_model.sv
tests/tb_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_bridge \
    --Mdir obj_dir -o sim_axi_bridge \
    -f axi_bridge.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_axi_bridge)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tests/tb_axi_bridge.sv ====
`timescale 1ns/10ps

module tb_axi_bridge
    import axi_bridge_pkg::*;
;

    // About ten bursts of up to 8 beats with random stalls; far below this
    localparam int CYCLE_LIMIT = 4000;

    logic        clk;
    logic        resetn;
    logic        inst_req;
    sram_req_t   inst_info;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;
    logic        data_req;
    sram_req_t   data_info;
    w_beat_t     data_wbeat;
    logic        data_wvalid;
    logic        data_addr_ok;
    logic        data_data_ok;
    logic        data_rlast;
    logic [31:0] data_rdata;
    axi_addr_t   ar;
    logic        arvalid;
    logic        arready;
    axi_rbeat_t  r;
    logic        rvalid;
    logic        rready;
    axi_addr_t   aw;
    logic        awvalid;
    logic        awready;
    w_beat_t     w;
    logic        wvalid;
    logic        wready;
    logic [3:0]  bid;
    logic        bvalid;
    logic        bready;

    // Reference memory and expectations
    logic [31:0] ref_mem [256];
    logic [31:0] inst_exp;
    logic [31:0] rd_expect;
    logic [7:0]  rd_base;
    logic [7:0]  rd_len;
    logic [8:0]  rd_beat;
    logic        rd_active;
    logic        wr_wait;
    int          error_count;
    int          test_count;
    int          cycle_count;

    axi_bridge u_axi_bridge (.*);
    axi_slave_model u_slave (.*);

    initial begin
        clk = 1'b0;
    end
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Read beats counted per burst; the write's data_ok is not a beat
    always_ff @(posedge clk) begin
        if (!rd_active) begin
            rd_beat <= '0;
        end else if (data_data_ok && !wr_wait) begin
            rd_beat <= rd_beat + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_wait <= 1'b0;
        end else if (data_req && data_info.wr && data_addr_ok) begin
            wr_wait <= 1'b1;
        end else if (data_data_ok) begin
            wr_wait <= 1'b0;
        end
    end

    assign rd_expect = ref_mem[rd_base + rd_beat[7:0]];

    function automatic logic [31:0] pattern_word(input logic [7:0] idx);
        return {idx ^ 8'hc0, idx, ~idx, idx + 8'h3c};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic flag_error(input string msg);
        error_count++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    a_reset_quiet: assert property (@(posedge clk)
        !resetn |=> !arvalid && !awvalid && !wvalid && !inst_data_ok && !data_data_ok)
        else flag_error("valid or data_ok high right after reset");
    a_inst_data: assert property (@(posedge clk) disable iff (!resetn)
        inst_data_ok |-> inst_rdata == inst_exp)
        else flag_error("inst_rdata differs from memory word");
    a_data_beat: assert property (@(posedge clk) disable iff (!resetn)
        rd_active && data_data_ok && !wr_wait |-> data_rdata == rd_expect)
        else flag_error("data_rdata differs from expected word");
    a_data_last: assert property (@(posedge clk) disable iff (!resetn)
        rd_active && data_data_ok && !wr_wait |-> data_rlast == (rd_beat == {1'b0, rd_len}))
        else flag_error("data_rlast wrong for beat position");
    a_data_wins: assert property (@(posedge clk) disable iff (!resetn)
        inst_req && data_req && !data_info.wr && !wr_wait |-> !inst_addr_ok)
        else flag_error("inst_addr_ok high while a data read was requested");
    a_data_granted: assert property (@(posedge clk) disable iff (!resetn)
        inst_req && data_req && !data_info.wr && !wr_wait && !arvalid |-> data_addr_ok)
        else flag_error("data read not granted with AR free");
    a_read_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_wait && data_req && !data_info.wr && !data_data_ok |-> !data_addr_ok)
        else flag_error("data read accepted while a write awaited its response");
    a_ar_hold: assert property (@(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else flag_error("AR payload not held while arready low");
    a_aw_hold: assert property (@(posedge clk) disable iff (!resetn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else flag_error("AW payload not held while awready low");
    a_w_hold: assert property (@(posedge clk) disable iff (!resetn)
        wvalid && !wready |=> wvalid && $stable(w))
        else flag_error("W payload not held while wready low");
    a_ready_high: assert property (@(posedge clk) disable iff (!resetn)
        rready && bready)
        else flag_error("rready or bready not held high");

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_grant(input bit is_data);
        bit got;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            got = is_data ? data_addr_ok : inst_addr_ok;
            step();
        end
    endtask

    task automatic inst_read(input logic [31:0] addr);
        bit got;
        got = 1'b0;
        inst_exp = ref_mem[addr[9:2]];
        inst_info = '{wr: 1'b0, size: 2'd2, addr: addr, len: 8'd0};
        inst_req = 1'b1;
        wait_grant(1'b0);
        inst_req = 1'b0;
        while (!got) begin
            @(negedge clk);
            got = inst_data_ok;
        end
        step();
    endtask

    task automatic data_read(input logic [31:0] addr, input logic [7:0] len);
        rd_base = addr[9:2];
        rd_len = len;
        rd_active = 1'b1;
        data_info = '{wr: 1'b0, size: 2'd2, addr: addr, len: len};
        data_req = 1'b1;
        wait_grant(1'b1);
        data_req = 1'b0;
        while (rd_beat != {1'b0, len} + 9'd1) begin
            @(negedge clk);
        end
        step();
        rd_active = 1'b0;
        step();
    endtask

    task automatic data_write(input logic [31:0] addr, input int beats, input logic [3:0] strb);
        logic [31:0] word;
        logic [7:0]  idx;
        idx = addr[9:2];
        data_info = '{wr: 1'b1, size: 2'd2, addr: addr, len: 8'(beats - 1)};
        data_req = 1'b1;
        wait_grant(1'b1);
        data_req = 1'b0;
        for (int i = 0; i < beats; i++) begin
            word = $urandom;
            data_wbeat = '{data: word, strb: strb, last: (i == beats - 1)};
            data_wvalid = 1'b1;
            ref_mem[idx] = merge_bytes(ref_mem[idx], word, strb);
            idx = idx + 8'd1;
            step();
        end
        data_wvalid = 1'b0;
    endtask

    task automatic wait_write_done;
        while (wr_wait) begin
            @(negedge clk);
        end
        step();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    initial begin
        int errs;
        void'($urandom(32'hf9c8));
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = pattern_word(8'(i));
        end
        resetn = 1'b0;
        inst_req = 1'b0;
        inst_info = '0;
        data_req = 1'b0;
        data_info = '0;
        data_wbeat = '0;
        data_wvalid = 1'b0;
        inst_exp = '0;
        rd_base = '0;
        rd_len = '0;
        rd_active = 1'b0;
        error_count = 0;
        test_count = 0;
        cycle_count = 0;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        errs = error_count;
        repeat (4) step();
        finish_test("reset state", errs);

        errs = error_count;
        inst_read(32'h40);
        inst_read(32'h3fc);
        data_read(32'h80, 8'd3);
        data_read(32'h10, 8'd0);
        finish_test("single and burst reads", errs);

        errs = error_count;
        fork
            inst_read(32'h20);
            data_read(32'hc0, 8'd1);
        join
        finish_test("same-cycle arbitration", errs);

        errs = error_count;
        data_write(32'h100, 4, 4'hf);
        wait_write_done();
        data_read(32'h100, 8'd3);
        data_write(32'h200, 2, 4'b0101);
        wait_write_done();
        data_read(32'h1fc, 8'd3);
        finish_test("write and read back", errs);

        errs = error_count;
        data_write(32'h300, 3, 4'b1100);
        data_read(32'h300, 8'd2);
        wait_write_done();
        finish_test("read held behind write", errs);

        errs = error_count;
        data_write(32'h380, 8, 4'hf);
        wait_write_done();
        data_read(32'h380, 8'd7);
        inst_read(32'h384);
        finish_test("payload stability", errs);

        $display("Summary: %0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tests/axi_slave_model.sv ====
`timescale 1ns/10ps

module axi_slave_model
    import axi_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  axi_addr_t  ar,
    input  logic       arvalid,
    output logic       arready,
    output axi_rbeat_t r,
    output logic       rvalid,
    input  logic       rready,
    input  axi_addr_t  aw,
    input  logic       awvalid,
    output logic       awready,
    input  w_beat_t    w,
    input  logic       wvalid,
    output logic       wready,
    output logic [3:0] bid,
    output logic       bvalid,
    input  logic       bready
);

    // 256 words, indexed by addr[9:2]
    logic [31:0] mem [256];
    logic        rd_busy;
    logic [7:0]  rd_addr;
    logic [7:0]  rd_left;
    logic [3:0]  rd_id;
    logic        wr_open;
    logic [7:0]  wr_addr;

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'hc0, idx, ~idx, idx + 8'h3c};
    endfunction

    function automatic logic [31:0] write_bytes(input logic [31:0] old, input w_beat_t beat);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (beat.strb[b]) begin
                res[b*8 +: 8] = beat.data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // One read burst at a time, beats in order with random gaps
    always_ff @(posedge clk) begin
        if (!resetn) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rd_busy <= 1'b0;
            r <= '0;
            rd_addr <= '0;
            rd_left <= '0;
            rd_id <= '0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_addr <= ar.addr[9:2];
                rd_left <= ar.len;
                rd_id <= ar.id;
            end else if (!rd_busy) begin
                arready <= (($urandom % 3) == 0);
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                if (r.last) begin
                    rd_busy <= 1'b0;
                end
            end else if (rd_busy && !rvalid && (($urandom % 2) == 0)) begin
                rvalid <= 1'b1;
                r <= '{id: rd_id, data: mem[rd_addr], last: (rd_left == 8'd0)};
                rd_addr <= rd_addr + 8'd1;
                rd_left <= rd_left - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(8'(i));
            end
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bid <= '0;
            wr_open <= 1'b0;
            wr_addr <= '0;
        end else begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                wr_open <= 1'b1;
                wr_addr <= aw.addr[9:2];
                bid <= aw.id;
            end else if (!wr_open && !bvalid) begin
                awready <= (($urandom % 3) == 0);
            end
            if (wvalid && wready) begin
                mem[wr_addr] <= write_bytes(mem[wr_addr], w);
                wr_addr <= wr_addr + 8'd1;
                wready <= 1'b0;
                if (w.last) begin
                    wr_open <= 1'b0;
                    bvalid <= 1'b1;
                end
            end else begin
                wready <= wr_open && (($urandom % 2) == 0);
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/axi_bridge.sv ====
`timescale 1ns/10ps

module axi_bridge
    import axi_bridge_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    input  logic        inst_req,
    input  sram_req_t   inst_info,
    output logic        inst_addr_ok,
    output logic        inst_data_ok,
    output logic [31:0] inst_rdata,

    input  logic        data_req,
    input  sram_req_t   data_info,
    input  w_beat_t     data_wbeat,
    input  logic        data_wvalid,
    output logic        data_addr_ok,
    output logic        data_data_ok,
    output logic        data_rlast,
    output logic [31:0] data_rdata,

    output axi_addr_t   ar,
    output logic        arvalid,
    input  logic        arready,

    input  axi_rbeat_t  r,
    input  logic        rvalid,
    output logic        rready,

    output axi_addr_t   aw,
    output logic        awvalid,
    input  logic        awready,

    output w_beat_t     w,
    output logic        wvalid,
    input  logic        wready,

    input  logic [3:0]  bid,
    input  logic        bvalid,
    output logic        bready
);

    req_kind_t  kind;
    axi_addr_t  ar_payload;
    axi_addr_t  aw_payload;
    axi_rbeat_t beat;
    w_beat_t    fifo_head;
    logic       ar_empty;
    logic       ar_load;
    logic       aw_idle;
    logic       aw_start;
    logic       beat_valid;
    logic       fifo_empty;
    logic       fifo_pop;
    logic       write_busy;
    logic       b_done;
    logic       b_ok;

    // Data port first; its reads wait out pending writes
    always_comb begin
        if (data_req && data_info.wr) begin
            kind = REQ_DATA_WRITE;
        end else if (data_req && !write_busy) begin
            kind = REQ_DATA_READ;
        end else if (inst_req && !inst_info.wr) begin
            kind = REQ_INST_READ;
        end else begin
            kind = REQ_NONE;
        end
    end

    assign inst_addr_ok = (kind == REQ_INST_READ) && ar_empty;
    assign data_addr_ok = ((kind == REQ_DATA_WRITE) && aw_idle)
                       || ((kind == REQ_DATA_READ) && ar_empty);

    assign ar_load = ar_empty && (kind == REQ_INST_READ || kind == REQ_DATA_READ);
    assign aw_start = (kind == REQ_DATA_WRITE) && aw_idle;

    always_comb begin
        if (kind == REQ_DATA_READ) begin
            ar_payload = '{id: ID_DATA, addr: data_info.addr, len: data_info.len,
                           size: {1'b0, data_info.size}};
        end else begin
            ar_payload = '{id: ID_INST, addr: inst_info.addr, len: inst_info.len,
                           size: {1'b0, inst_info.size}};
        end
    end

    assign aw_payload = '{id: ID_DATA, addr: data_info.addr, len: data_info.len,
                          size: {1'b0, data_info.size}};

    // Read beats go back by ID
    assign inst_rdata = beat.data;
    assign data_rdata = beat.data;
    assign inst_data_ok = beat_valid && (beat.id == ID_INST);
    assign data_rlast = beat.last && (beat.id == ID_DATA);
    assign data_data_ok = (beat_valid && (beat.id == ID_DATA)) || b_ok;

    assign bready = 1'b1;
    assign b_done = bvalid && bready && (bid == ID_DATA);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            b_ok <= 1'b0;
        end else begin
            b_ok <= b_done;
        end
    end

    axi_ar_channel u_ar (
        .clk     (clk),
        .resetn  (resetn),
        .load    (ar_load),
        .payload (ar_payload),
        .empty   (ar_empty),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready)
    );

    axi_r_channel u_r (
        .clk        (clk),
        .resetn     (resetn),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    axi_aw_channel u_aw (
        .clk        (clk),
        .resetn     (resetn),
        .start      (aw_start),
        .payload    (aw_payload),
        .idle       (aw_idle),
        .fifo_beat  (fifo_head),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready)
    );

    w_beat_fifo u_w_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (data_wvalid),
        .push_beat (data_wbeat),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty)
    );

    write_pending_counter u_pending (
        .clk        (clk),
        .resetn     (resetn),
        .issue      (aw_start),
        .done       (b_done),
        .write_busy (write_busy)
    );

    a_one_grant: assert property (@(posedge clk) disable iff (!resetn)
        !(inst_addr_ok && data_addr_ok))
        else $error("Both ports granted in one cycle");

endmodule

// ==== source/write_pending_counter.sv ====
`timescale 1ns/10ps

module write_pending_counter
    import axi_bridge_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic issue,
    input  logic done,
    output logic write_busy
);

    logic [PENDING_W-1:0] pending;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= '0;
        end else if (issue && !done) begin
            pending <= pending + 1'b1;
        end else if (done && !issue) begin
            pending <= pending - 1'b1;
        end
    end

    assign write_busy = (pending != '0);

    // A B response with no write outstanding
    property p_no_underflow;
        @(posedge clk) disable iff (!resetn)
        done && !issue |-> pending != '0;
    endproperty
    a_no_underflow: assert property (p_no_underflow)
        else $error("B response without a pending write");

endmodule

// ==== source/w_beat_fifo.sv ====
`timescale 1ns/10ps

module w_beat_fifo
    import axi_bridge_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    push,
    input  w_beat_t push_beat,
    input  logic    pop,
    output w_beat_t head,
    output logic    empty
);

    w_beat_t mem [W_FIFO_DEPTH];

    logic [W_FIFO_PTR-1:0] wr_ptr;
    logic [W_FIFO_PTR-1:0] rd_ptr;
    logic [W_FIFO_PTR:0]   count;
    logic                  full;

    assign empty = (count == '0);
    assign full = (count == (W_FIFO_PTR + 1)'(W_FIFO_DEPTH));
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    // Burst length cap should keep this from firing
    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn) push && full |-> pop)
        else $error("Write beat FIFO overflow");

endmodule

// ==== source/axi_aw_channel.sv ====
`timescale 1ns/10ps

module axi_aw_channel
    import axi_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    input  axi_addr_t payload,
    output logic      idle,
    input  w_beat_t   fifo_beat,
    input  logic      fifo_empty,
    output logic      fifo_pop,
    output axi_addr_t aw,
    output logic      awvalid,
    input  logic      awready,
    output w_beat_t   w,
    output logic      wvalid,
    input  logic      wready
);

    aw_state_t state;
    aw_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            AW_IDLE: begin
                if (start) begin
                    state_next = AW_ADDR;
                end
            end
            AW_ADDR: begin
                if (awready) begin
                    state_next = AW_DATA;
                end
            end
            AW_DATA: begin
                // Burst ends once the last beat is taken
                if (fifo_pop && fifo_beat.last) begin
                    state_next = AW_IDLE;
                end
            end
            default: state_next = AW_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= AW_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == AW_IDLE && start) begin
            aw <= payload;
        end
    end

    assign idle = (state == AW_IDLE);
    assign awvalid = (state == AW_ADDR);

    // W beats wait behind the address
    assign wvalid = (state == AW_DATA) && !fifo_empty;
    assign w = fifo_beat;
    assign fifo_pop = wvalid && wready;

    property p_no_pop_empty;
        @(posedge clk) disable iff (!resetn)
        fifo_pop |-> !fifo_empty;
    endproperty
    a_no_pop_empty: assert property (p_no_pop_empty)
        else $error("Write beat FIFO popped while empty");

endmodule

// ==== source/axi_r_channel.sv ====
`timescale 1ns/10ps

module axi_r_channel
    import axi_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  axi_rbeat_t r,
    input  logic       rvalid,
    output logic       rready,
    output axi_rbeat_t beat,
    output logic       beat_valid
);

    // Reads are never back-pressured
    assign rready = 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= rvalid && rready;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid) begin
            beat <= r;
        end
    end

endmodule

// ==== source/axi_ar_channel.sv ====
`timescale 1ns/10ps

module axi_ar_channel
    import axi_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      load,
    input  axi_addr_t payload,
    output logic      empty,
    output axi_addr_t ar,
    output logic      arvalid,
    input  logic      arready
);

    // Single entry, full exactly while arvalid is up
    always_ff @(posedge clk) begin
        if (!resetn) begin
            arvalid <= 1'b0;
        end else if (load) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ar <= payload;
        end
    end

    assign empty = !arvalid;

    // Address must not change while the slave stalls
    property p_ar_stable;
        @(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(ar);
    endproperty
    a_ar_stable: assert property (p_ar_stable)
        else $error("AR payload changed while waiting for arready");

endmodule

// ==== source/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // AXI IDs per requester
    localparam logic [3:0] ID_INST = 4'd1;
    localparam logic [3:0] ID_DATA = 4'd2;

    localparam int W_FIFO_DEPTH = 8;
    localparam int W_FIFO_PTR = $clog2(W_FIFO_DEPTH);

    // Enough for far more writes than can be in flight
    localparam int PENDING_W = 5;

    typedef struct packed {
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [7:0]  len;
    } sram_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } w_beat_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_addr_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic        last;
    } axi_rbeat_t;

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_INST_READ,
        REQ_DATA_READ,
        REQ_DATA_WRITE
    } req_kind_t;

    typedef enum logic [1:0] {
        AW_IDLE,
        AW_ADDR,
        AW_DATA
    } aw_state_t;

endpackage
